//--- verilog/adc_soc_pkg.sv
package adc_soc_pkg;

        // ----------------------------------------------------------
        // Bus widths
        // ----------------------------------------------------------
        typedef logic [31:0] apb_addr_t;
        typedef logic [31:0] apb_data_t;

        // ----------------------------------------------------------
        // ADC result
        // ----------------------------------------------------------
        localparam int ADC_WIDTH = 12;

        typedef logic [ADC_WIDTH-1:0] adc_code_t;

        // ----------------------------------------------------------
        // APB slot map, decoded from PADDR[15:12]
        // ----------------------------------------------------------
        typedef logic [3:0] slot_t;

        localparam slot_t ADC0_SLOT = 4'd0;
        localparam slot_t ADC1_SLOT = 4'd3;     // Slots 1 and 2 stay empty

        // Register offsets within one ADC slot
        localparam int REG_OFFSET_W = 4;

        localparam logic [REG_OFFSET_W-1:0] REG_CTRL   = 4'h0; // Bit 0 sample enable
        localparam logic [REG_OFFSET_W-1:0] REG_DATA   = 4'h4; // Latest code, read only
        localparam logic [REG_OFFSET_W-1:0] REG_STATUS = 4'h8; // Bit 0 new data

        // ----------------------------------------------------------
        // Sampling sequencer
        // ----------------------------------------------------------
        typedef enum logic [1:0] {
                IDLE,
                START,
                CONVERT,
                READ
        } sample_state_t;

endpackage

//--- verilog/apb_if.sv
`timescale 1ns/1ps

interface apb_if import adc_soc_pkg::*;;

        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;

        // Mux side
        modport requester (
                output psel, penable, pwrite, paddr, pwdata,
                input  prdata, pready, pslverr
        );

        // Register block side
        modport completer (
                input  psel, penable, pwrite, paddr, pwdata,
                output prdata, pready, pslverr
        );

endinterface

//--- verilog/apb_slave_mux.sv
`timescale 1ns/1ps

module apb_slave_mux import adc_soc_pkg::*; (
        // From the external APB requester
        input  logic      psel,
        input  logic      penable,
        input  logic      pwrite,
        input  apb_addr_t paddr,
        input  apb_data_t pwdata,
        output apb_data_t prdata,
        output logic      pready,
        output logic      pslverr,

        // To the ADC register blocks
        apb_if.requester  adc0,
        apb_if.requester  adc1
);

        slot_t slot;

        assign slot = paddr[15:12];

        // ----------------------------------------------------------
        // Select gating, shared fields go straight through
        // ----------------------------------------------------------
        assign adc0.psel    = psel && (slot == ADC0_SLOT);
        assign adc0.penable = penable;
        assign adc0.pwrite  = pwrite;
        assign adc0.paddr   = paddr;
        assign adc0.pwdata  = pwdata;

        assign adc1.psel    = psel && (slot == ADC1_SLOT);
        assign adc1.penable = penable;
        assign adc1.pwrite  = pwrite;
        assign adc1.paddr   = paddr;
        assign adc1.pwdata  = pwdata;

        // ----------------------------------------------------------
        // Response return
        // ----------------------------------------------------------
        always_comb begin
                case (slot)
                        ADC0_SLOT: begin
                                prdata  = adc0.prdata;
                                pready  = adc0.pready;
                                pslverr = adc0.pslverr;
                        end
                        ADC1_SLOT: begin
                                prdata  = adc1.prdata;
                                pready  = adc1.pready;
                                pslverr = adc1.pslverr;
                        end
                        default: begin          // Empty slot, zero wait, no error
                                prdata  = '0;
                                pready  = 1'b1;
                                pslverr = 1'b0;
                        end
                endcase
        end

        // Only one register block may see a transfer
        always_comb begin
                assert final (!(adc0.psel && adc1.psel))
                        else $error("apb_slave_mux: both ADC slots selected at once");
        end

endmodule

//--- verilog/apb_adc_regs.sv
`timescale 1ns/1ps

module apb_adc_regs import adc_soc_pkg::*; (
        input  logic      clk,
        input  logic      RSTn,

        apb_if.completer  bus,

        // From the converter
        input  adc_code_t code,
        input  logic      code_valid,

        // To the sampling sequencer
        output logic      sample_enable
);

        logic [REG_OFFSET_W-1:0] offset;
        logic                    access;
        logic                    wr_ctrl;
        logic                    rd_data;
        logic                    capture;

        adc_code_t               data;
        logic                    new_data;

        // ----------------------------------------------------------
        // Access decode
        // ----------------------------------------------------------
        assign offset  = bus.paddr[REG_OFFSET_W-1:0];
        assign access  = bus.psel && bus.penable;       // PREADY is always high
        assign wr_ctrl = access && bus.pwrite && (offset == REG_CTRL);
        assign rd_data = access && !bus.pwrite && (offset == REG_DATA);
        assign capture = code_valid && sample_enable;

        // Control register
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        sample_enable <= 1'b0;
                end else if (wr_ctrl) begin
                        sample_enable <= bus.pwdata[0];
                end
        end

        // Captured code and new-data flag
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        data     <= '0;
                        new_data <= 1'b0;
                end else if (capture) begin
                        data     <= code;
                        new_data <= 1'b1;       // Wins over a DATA read
                end else if (rd_data) begin
                        new_data <= 1'b0;
                end
        end

        // ----------------------------------------------------------
        // Read path, zero wait states
        // ----------------------------------------------------------
        always_comb begin
                bus.prdata = '0;
                case (offset)
                        REG_CTRL:   bus.prdata[0]           = sample_enable;
                        REG_DATA:   bus.prdata[ADC_WIDTH-1:0] = data;
                        REG_STATUS: bus.prdata[0]           = new_data;
                        default:    bus.prdata              = '0;
                endcase
        end

        assign bus.pready  = 1'b1;
        assign bus.pslverr = 1'b0;

        // Requester must not stall on this block
        assert property (@(posedge clk) disable iff (!RSTn)
                bus.psel |-> bus.pready)
                else $error("apb_adc_regs: pready low during a transfer");

        // Access phase always follows a selected setup phase
        assert property (@(posedge clk) disable iff (!RSTn)
                $rose(bus.penable) && bus.psel |-> $past(bus.psel))
                else $error("apb_adc_regs: penable rose without psel");

endmodule

//--- verilog/adc_sample_ctrl.sv
`timescale 1ns/1ps

module adc_sample_ctrl import adc_soc_pkg::*; (
        input  logic clk,
        input  logic RSTn,

        input  logic sample_enable0,
        input  logic sample_enable1,
        input  logic eoc,               // End of conversion from the converter

        output logic start,
        output logic oe
);

        sample_state_t state;
        sample_state_t state_next;
        logic          any_enable;

        assign any_enable = sample_enable0 || sample_enable1;

        // ----------------------------------------------------------
        // State register
        // ----------------------------------------------------------
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        state <= IDLE;
                end else begin
                        state <= state_next;
                end
        end

        // Next state
        always_comb begin
                state_next = state;
                case (state)
                        IDLE: begin
                                if (any_enable)
                                        state_next = START;
                        end
                        START:   state_next = CONVERT;  // Converter latches here
                        CONVERT: begin
                                if (eoc)
                                        state_next = READ;
                        end
                        READ:    state_next = IDLE;
                        default: state_next = IDLE;
                endcase
        end

        // One-cycle pulses decoded from the state
        assign start = (state == START);
        assign oe    = (state == READ);

        // ----------------------------------------------------------
        // Checks
        // ----------------------------------------------------------
        assert property (@(posedge clk) disable iff (!RSTn)
                !(start && oe))
                else $error("adc_sample_ctrl: start and oe high together");

        // Converter must only finish a round this FSM started
        assert property (@(posedge clk) disable iff (!RSTn)
                eoc |-> (state == CONVERT))
                else $error("adc_sample_ctrl: eoc outside CONVERT");

endmodule

//--- verilog/adc_converter.sv
`timescale 1ns/1ps

module adc_converter import adc_soc_pkg::*; #(
        parameter int CONV_CYCLES = 8
) (
        input  logic      clk,
        input  logic      RSTn,

        input  apb_data_t real_data0,   // Analog words
        input  apb_data_t real_data1,

        input  logic      start,
        input  logic      oe,
        output logic      eoc,

        output adc_code_t code0,
        output adc_code_t code1,
        output logic      code_valid
);

        localparam int CNT_W = (CONV_CYCLES > 1) ? $clog2(CONV_CYCLES) : 1;

        apb_data_t  hold0;
        apb_data_t  hold1;
        logic       busy;
        logic [CNT_W-1:0] cnt;

        // Sample and hold
        always_ff @(posedge clk) begin
                if (start) begin
                        hold0 <= real_data0;
                        hold1 <= real_data1;
                end
        end

        // ----------------------------------------------------------
        // Conversion counter, eoc after CONV_CYCLES busy cycles
        // ----------------------------------------------------------
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        busy <= 1'b0;
                        cnt  <= '0;
                        eoc  <= 1'b0;
                end else begin
                        eoc <= 1'b0;
                        if (start) begin
                                busy <= 1'b1;
                                cnt  <= '0;
                        end else if (busy) begin
                                if (cnt == CNT_W'(CONV_CYCLES - 1)) begin
                                        busy <= 1'b0;
                                        eoc  <= 1'b1;
                                end else begin
                                        cnt <= cnt + 1'b1;
                                end
                        end
                end
        end

        // Output register, top bits of the held words
        always_ff @(posedge clk) begin
                if (oe) begin
                        code0 <= hold0[$bits(apb_data_t)-1 -: ADC_WIDTH];
                        code1 <= hold1[$bits(apb_data_t)-1 -: ADC_WIDTH];
                end
        end

        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn)
                        code_valid <= 1'b0;
                else
                        code_valid <= oe;       // Codes are stable from here on
        end

        assert property (@(posedge clk) disable iff (!RSTn)
                eoc |-> $past(busy))
                else $error("adc_converter: eoc without a running conversion");

endmodule

//--- verilog/adc_apb_subsystem.sv
`timescale 1ns/1ps

module adc_apb_subsystem import adc_soc_pkg::*; #(
        parameter int CONV_CYCLES = 8
) (
        input  logic      clk,
        input  logic      RSTn,

        // APB from the external requester
        input  logic      psel,
        input  logic      penable,
        input  logic      pwrite,
        input  apb_addr_t paddr,
        input  apb_data_t pwdata,
        output apb_data_t prdata,
        output logic      pready,
        output logic      pslverr,

        // Analog inputs
        input  apb_data_t real_data0,
        input  apb_data_t real_data1
);

        logic      sample_enable0;
        logic      sample_enable1;
        logic      start;
        logic      eoc;
        logic      oe;
        adc_code_t code0;
        adc_code_t code1;
        logic      code_valid;

        // ----------------------------------------------------------
        // APB side
        // ----------------------------------------------------------
        apb_if apb_adc0 ();
        apb_if apb_adc1 ();

        apb_slave_mux apb_mux (
                .psel    (psel),
                .penable (penable),
                .pwrite  (pwrite),
                .paddr   (paddr),
                .pwdata  (pwdata),
                .prdata  (prdata),
                .pready  (pready),
                .pslverr (pslverr),
                .adc0    (apb_adc0.requester),
                .adc1    (apb_adc1.requester)
        );

        apb_adc_regs adc0_regs (
                .clk           (clk),
                .RSTn          (RSTn),
                .bus           (apb_adc0.completer),
                .code          (code0),
                .code_valid    (code_valid),
                .sample_enable (sample_enable0)
        );

        apb_adc_regs adc1_regs (
                .clk           (clk),
                .RSTn          (RSTn),
                .bus           (apb_adc1.completer),
                .code          (code1),
                .code_valid    (code_valid),
                .sample_enable (sample_enable1)
        );

        // ----------------------------------------------------------
        // Sampling path
        // ----------------------------------------------------------
        adc_sample_ctrl sample_ctrl (
                .clk            (clk),
                .RSTn           (RSTn),
                .sample_enable0 (sample_enable0),
                .sample_enable1 (sample_enable1),
                .eoc            (eoc),
                .start          (start),
                .oe             (oe)
        );

        adc_converter #(
                .CONV_CYCLES (CONV_CYCLES)
        ) converter (
                .clk        (clk),
                .RSTn       (RSTn),
                .real_data0 (real_data0),
                .real_data1 (real_data1),
                .start      (start),
                .oe         (oe),
                .eoc        (eoc),
                .code0      (code0),
                .code1      (code1),
                .code_valid (code_valid)
        );

endmodule

//--- verification/tb_adc_apb_subsystem.sv
`timescale 1ns/1ps

module tb_adc_apb_subsystem import adc_soc_pkg::*;;

        localparam int CONV_CYCLES  = 8;
        localparam int ROUND_CYCLES = CONV_CYCLES + 6;  // One sequencer round with slack
        localparam int POLL_LIMIT   = 3 * ROUND_CYCLES; // STATUS reads before giving up
        localparam int CTRL_TRIALS  = 8;
        localparam int EMPTY_TRIALS = 8;

        // Transfers per test section, three cycles each
        localparam int TRANSFERS = 6 + 2 * (2 * CTRL_TRIALS + 7) + 2 * (POLL_LIMIT + 7)
                                 + (2 * POLL_LIMIT + 10) + 4 * EMPTY_TRIALS + 6;
        localparam int TIMEOUT_CYCLES = 2 * (3 * TRANSFERS + 8 * ROUND_CYCLES + 4);

        logic      clk;
        logic      RSTn;
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
        apb_data_t real_data0;
        apb_data_t real_data1;

        logic [31:0] lfsr;
        int          value_errors;
        int          poll_errors;
        int          cycle_count;

        // Register model, one entry per channel
        logic        model_enable [2];
        adc_code_t   model_code [2];
        logic        model_flag [2];
        apb_data_t   word [2];

        adc_apb_subsystem #(
                .CONV_CYCLES (CONV_CYCLES)
        ) adc_apb_subsystem_inst (
                .clk        (clk),
                .RSTn       (RSTn),
                .psel       (psel),
                .penable    (penable),
                .pwrite     (pwrite),
                .paddr      (paddr),
                .pwdata     (pwdata),
                .prdata     (prdata),
                .pready     (pready),
                .pslverr    (pslverr),
                .real_data0 (real_data0),
                .real_data1 (real_data1)
        );

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        // ----------------------------------------------------------
        // Helpers
        // ----------------------------------------------------------
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
        endfunction

        function automatic apb_data_t random_bits(input int n);
                apb_data_t r;
                r = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr = lfsr_next(lfsr);
                        r    = {r[30:0], lfsr[0]};
                end
                return r;
        endfunction

        function automatic slot_t channel_slot(input int ch);
                return (ch == 0) ? ADC0_SLOT : ADC1_SLOT;
        endfunction

        function automatic apb_addr_t reg_addr(input slot_t s, input logic [REG_OFFSET_W-1:0] o);
                return {16'h0, s, 8'h0, o};
        endfunction

        task automatic check_value(input string name, input apb_data_t expected,
                                   input apb_data_t actual);
                assert (actual === expected) else begin
                        value_errors++;
                        $display("Error at %0t ns: %s expected %h, got %h",
                                 $time, name, expected, actual);
                end
        endtask

        task automatic transfer(input logic write, input apb_addr_t addr, input apb_data_t data,
                                output apb_data_t rdata);
                @(posedge clk);                         // Setup cycle
                psel    <= 1'b1;
                penable <= 1'b0;
                pwrite  <= write;
                paddr   <= addr;
                pwdata  <= data;
                @(posedge clk);                         // Access cycle
                penable <= 1'b1;
                @(negedge clk);
                rdata = prdata;
                check_value("pready", 32'd1, {31'd0, pready});
                check_value("pslverr", 32'd0, {31'd0, pslverr});
                @(posedge clk);
                psel    <= 1'b0;
                penable <= 1'b0;
        endtask

        task automatic expect_read(input apb_addr_t addr, input string name,
                                   input apb_data_t expected);
                apb_data_t rd;
                transfer(1'b0, addr, '0, rd);
                check_value($sformatf("prdata (%s @%h)", name, addr), expected, rd);
        endtask

        // Reads CTRL, STATUS, then DATA, which clears the flag
        task automatic check_channel(input int ch);
                expect_read(reg_addr(channel_slot(ch), REG_CTRL), "CTRL",
                            {31'd0, model_enable[ch]});
                expect_read(reg_addr(channel_slot(ch), REG_STATUS), "STATUS",
                            {31'd0, model_flag[ch]});
                expect_read(reg_addr(channel_slot(ch), REG_DATA), "DATA",
                            {{(32-ADC_WIDTH){1'b0}}, model_code[ch]});
                model_flag[ch] = 1'b0;
        endtask

        task automatic set_enable(input int ch, input logic en);
                apb_data_t rd;
                apb_data_t v;
                v = random_bits(31);
                transfer(1'b1, reg_addr(channel_slot(ch), REG_CTRL), {v[30:0], en}, rd);
                model_enable[ch] = en;
                if (!en)
                        repeat (ROUND_CYCLES) @(posedge clk);   // Let an open round drain
        endtask

        task automatic drive_words();
                word[0] = random_bits(32);
                word[1] = random_bits(32);
                while (word[1][31 -: ADC_WIDTH] == word[0][31 -: ADC_WIDTH])
                        word[1] = random_bits(32);
                @(posedge clk);
                real_data0 <= word[0];
                real_data1 <= word[1];
        endtask

        task automatic wait_for_flag(input int ch);
                apb_data_t rd;
                int        polls;
                rd    = '0;
                polls = 0;
                while (!rd[0] && polls < POLL_LIMIT) begin
                        transfer(1'b0, reg_addr(channel_slot(ch), REG_STATUS), '0, rd);
                        polls++;
                end
                assert (rd[0]) else begin
                        poll_errors++;
                        $display("Channel %0d never raised its new-data flag in %0d STATUS reads",
                                 ch, POLL_LIMIT);
                end
                if (rd[0]) begin
                        model_flag[ch] = 1'b1;
                        model_code[ch] = word[ch][31 -: ADC_WIDTH];
                end
        endtask

        // ----------------------------------------------------------
        // Test sequence
        // ----------------------------------------------------------
        initial begin
                apb_data_t               rd;
                apb_data_t               v;
                logic [REG_OFFSET_W-1:0] off;
                slot_t                   s;
                lfsr         = 32'h9f88682b;
                value_errors = 0;
                poll_errors  = 0;
                RSTn         = 1'b0;
                psel         = 1'b0;
                penable      = 1'b0;
                pwrite       = 1'b0;
                paddr        = '0;
                pwdata       = '0;
                real_data0   = '0;              // Zero words keep early captures at code 0
                real_data1   = '0;
                for (int ch = 0; ch < 2; ch++) begin
                        model_enable[ch] = 1'b0;
                        model_code[ch]   = '0;
                        model_flag[ch]   = 1'b0;
                        word[ch]         = '0;
                end
                repeat (4) @(posedge clk);
                RSTn <= 1'b1;

                check_channel(0);               // Reset values
                check_channel(1);

                // CTRL readback, read-only DATA and STATUS
                for (int ch = 0; ch < 2; ch++) begin
                        for (int i = 0; i < CTRL_TRIALS; i++) begin
                                v = random_bits(32);
                                transfer(1'b1, reg_addr(channel_slot(ch), REG_CTRL), v, rd);
                                model_enable[ch] = v[0];
                                expect_read(reg_addr(channel_slot(ch), REG_CTRL), "CTRL",
                                            {31'd0, v[0]});
                        end
                        set_enable(ch, 1'b0);
                        expect_read(reg_addr(channel_slot(ch), REG_DATA), "DATA", '0);
                        model_flag[ch] = 1'b0;
                        transfer(1'b1, reg_addr(channel_slot(ch), REG_DATA), random_bits(32), rd);
                        transfer(1'b1, reg_addr(channel_slot(ch), REG_STATUS),
                                 random_bits(32) | 32'h1, rd);
                        check_channel(ch);
                end

                // One channel at a time
                for (int ch = 0; ch < 2; ch++) begin
                        drive_words();
                        set_enable(ch, 1'b1);
                        wait_for_flag(ch);
                        set_enable(ch, 1'b0);
                        expect_read(reg_addr(channel_slot(ch), REG_DATA), "DATA",
                                    {{(32-ADC_WIDTH){1'b0}}, model_code[ch]});
                        model_flag[ch] = 1'b0;
                        expect_read(reg_addr(channel_slot(ch), REG_STATUS), "STATUS", '0);
                        check_channel(1 - ch);  // Idle channel untouched
                end

                // Both channels together
                drive_words();
                set_enable(0, 1'b1);
                set_enable(1, 1'b1);
                wait_for_flag(0);
                wait_for_flag(1);
                set_enable(0, 1'b0);
                set_enable(1, 1'b0);
                check_channel(0);
                check_channel(1);

                // Empty slots first, slots 1 and 2 always among them
                for (int i = 0; i < EMPTY_TRIALS; i++) begin
                        if (i < 2) begin
                                s = slot_t'(i + 1);
                        end else begin
                                s = slot_t'(random_bits(4));
                                while (s == ADC0_SLOT || s == ADC1_SLOT)
                                        s = slot_t'(random_bits(4));
                        end
                        off = REG_OFFSET_W'(random_bits(REG_OFFSET_W));
                        expect_read(reg_addr(s, off), "empty slot", '0);
                        transfer(1'b1, reg_addr(s, REG_CTRL), random_bits(32) | 32'h1, rd);
                end
                // Unused offsets inside the ADC slots
                for (int i = 0; i < EMPTY_TRIALS; i++) begin
                        off = REG_OFFSET_W'(random_bits(REG_OFFSET_W));
                        while (off == REG_CTRL || off == REG_DATA || off == REG_STATUS)
                                off = REG_OFFSET_W'(random_bits(REG_OFFSET_W));
                        s = channel_slot(i % 2);
                        expect_read(reg_addr(s, off), "unused offset", '0);
                        transfer(1'b1, reg_addr(s, off), random_bits(32) | 32'h1, rd);
                end
                check_channel(0);
                check_channel(1);

                $display("Errors: %0d wrong values, %0d missing flags", value_errors, poll_errors);
                if (value_errors == 0 && poll_errors == 0)
                        $display("Simulation finished: PASS");
                else
                        $display("Simulation finished: FAIL");
                $finish;
        end

        // Watchdog
        initial begin
                cycle_count = 0;
                while (cycle_count < TIMEOUT_CYCLES) begin
                        @(posedge clk);
                        cycle_count++;
                end
                $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("Simulation finished: FAIL");
                $finish;
        end

endmodule

//--- adc_apb_subsystem.f
verilog/adc_soc_pkg.sv
verilog/apb_if.sv
verilog/apb_slave_mux.sv
verilog/apb_adc_regs.sv
verilog/adc_sample_ctrl.sv
verilog/adc_converter.sv
verilog/adc_apb_subsystem.sv
verification/tb_adc_apb_subsystem.sv

//--- Bender.yml
package:
  name: adc_apb_subsystem

sources:
  - files:
      - verilog/adc_soc_pkg.sv
      - verilog/apb_if.sv
      - verilog/apb_slave_mux.sv
      - verilog/apb_adc_regs.sv
      - verilog/adc_sample_ctrl.sv
      - verilog/adc_converter.sv
      - verilog/adc_apb_subsystem.sv
  - target: test
    files:
      - verification/tb_adc_apb_subsystem.sv
